// File: rtl/spi_pkg.sv
// shared SPI peripheral types: sub-peripheral addresses, framer states, byte strobe, FIFO sizing

package spi_pkg;

    // ####################
    // sub-peripheral map

    // first byte of every chip select window
    typedef enum logic [7:0] {
        ADDR_CHECKSUM = 8'hA0,
        ADDR_FIFO     = 8'hB5
    } sub_addr_e;

    // ####################
    // framer

    typedef enum logic [1:0] {
        FR_IDLE,
        FR_ADDRESS,
        FR_DATA
    } framer_state_e;

    // one byte with a single-cycle valid, no back-pressure
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_strobe_t;

    // ####################
    // scratch FIFO

    localparam int FIFO_DEPTH = 4;

    // pointers wrap naturally, depth must stay a power of two
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    localparam logic [FIFO_PTR_W:0] FIFO_FULL_COUNT = (FIFO_PTR_W + 1)'(FIFO_DEPTH);

    // answer for a pop from an empty FIFO
    localparam logic [7:0] FIFO_EMPTY_REPLY = 8'h00;

endpackage

// File: rtl/spi_byte_shifter.sv
// SPI mode 0 byte shifter: pin synchronizers, sclk edge detect, receive and transmit shift registers
`timescale 1ns/1ps

module spi_byte_shifter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sclk,
    input  logic                  cs_n,
    input  logic                  copi,
    input  spi_pkg::byte_strobe_t tx_byte,
    output logic                  cipo,
    output spi_pkg::byte_strobe_t rx_byte,
    output logic                  cs_active
);

    logic [1:0] sclk_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] copi_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_shift;
    logic [7:0] tx_hold;
    logic       tx_pending;

    // ####################
    // pin synchronizers

    // cs_n idles high so its flops reset to one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= 2'b00;
            cs_n_sync <= 2'b11;
            copi_sync <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            cs_n_sync <= {cs_n_sync[0], cs_n};
            copi_sync <= {copi_sync[0], copi};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign cs_active = ~cs_n_sync[1];

    // edges only count inside a chip select window
    assign sclk_rise = cs_active & sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = cs_active & ~sclk_sync[1] & sclk_prev;

    // ####################
    // receive side

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!cs_active) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt  <= bit_cnt + 3'd1;
                rx_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    // MSB first, eighth bit completes the byte
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], copi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_data <= {rx_shift[6:0], copi_sync[1]};
            end
        end
    end

    assign rx_byte = '{valid: rx_valid, data: rx_data};

    // ####################
    // transmit side

    always_ff @(posedge clk) begin
        if (tx_byte.valid) begin
            tx_hold <= tx_byte.data;
        end
    end

    // falling edge with bit_cnt at zero is the start of the next byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift   <= 8'h00;
            tx_pending <= 1'b0;
        end else if (!cs_active) begin
            tx_shift   <= 8'h00;
            tx_pending <= 1'b0;
        end else begin
            if (tx_byte.valid) begin
                tx_pending <= 1'b1;
            end
            if (sclk_fall) begin
                if (bit_cnt == 3'd0) begin
                    tx_shift   <= tx_pending ? tx_hold : 8'h00;
                    tx_pending <= 1'b0;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    assign cipo = tx_shift[7];

endmodule

// File: rtl/spi_transaction_framer.sv
// transaction framer: splits a chip select window into an address byte and data bytes
`timescale 1ns/1ps

module spi_transaction_framer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cs_active,
    input  spi_pkg::byte_strobe_t rx_byte,
    output logic [7:0]            address_in,
    output logic                  address_valid,
    output spi_pkg::byte_strobe_t data_byte
);

    spi_pkg::framer_state_e state;

    logic       data_valid;
    logic [7:0] data_q;

    // ####################
    // window FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= spi_pkg::FR_IDLE;
            address_valid <= 1'b0;
            data_valid    <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            if (!cs_active) begin
                // window closed, drop the selection
                state         <= spi_pkg::FR_IDLE;
                address_valid <= 1'b0;
            end else begin
                case (state)
                    spi_pkg::FR_IDLE: begin
                        state <= spi_pkg::FR_ADDRESS;
                    end
                    spi_pkg::FR_ADDRESS: begin
                        if (rx_byte.valid) begin
                            address_valid <= 1'b1;
                            state         <= spi_pkg::FR_DATA;
                        end
                    end
                    spi_pkg::FR_DATA: begin
                        data_valid <= rx_byte.valid;
                    end
                    default: begin
                        state <= spi_pkg::FR_IDLE;
                    end
                endcase
            end
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (rx_byte.valid && state == spi_pkg::FR_ADDRESS) begin
            address_in <= rx_byte.data;
        end
        if (rx_byte.valid) begin
            data_q <= rx_byte.data;
        end
    end

    assign data_byte = '{valid: data_valid, data: data_q};

endmodule

// File: rtl/spi_subperipheral_selector.sv
// sub-peripheral selector: address decode, write routing and reply return path
`timescale 1ns/1ps

module spi_subperipheral_selector (
    input  logic [7:0]            address_in,
    input  logic                  address_valid,

    // framer side and shifter side
    input  spi_pkg::byte_strobe_t peripheral_data_in,
    output spi_pkg::byte_strobe_t peripheral_data_out,

    // checksum unit
    output logic                  checksum_enable,
    output spi_pkg::byte_strobe_t checksum_wr,
    input  spi_pkg::byte_strobe_t checksum_reply,

    // scratch FIFO
    output logic                  fifo_enable,
    output spi_pkg::byte_strobe_t fifo_wr,
    input  spi_pkg::byte_strobe_t fifo_reply
);

    always_comb begin
        // nothing selected unless a known address is held
        peripheral_data_out = '0;

        checksum_enable = 1'b0;
        checksum_wr     = '0;

        fifo_enable = 1'b0;
        fifo_wr     = '0;

        if (address_valid) begin
            case (spi_pkg::sub_addr_e'(address_in))
                spi_pkg::ADDR_CHECKSUM: begin
                    peripheral_data_out = checksum_reply;

                    checksum_enable = 1'b1;
                    checksum_wr     = peripheral_data_in;
                end

                spi_pkg::ADDR_FIFO: begin
                    peripheral_data_out = fifo_reply;

                    fifo_enable = 1'b1;
                    fifo_wr     = peripheral_data_in;
                end

                default: begin
                    // unknown address, data bytes fall on the floor
                    peripheral_data_out = '0;
                end
            endcase
        end
    end

endmodule

// File: rtl/spi_checksum_unit.sv
// checksum sub-peripheral: running modulo-256 sum of written bytes
`timescale 1ns/1ps

module spi_checksum_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  spi_pkg::byte_strobe_t wr,
    output spi_pkg::byte_strobe_t reply
);

    logic [7:0] sum;
    logic [7:0] next_sum;
    logic       enable_prev;

    // carry out is dropped, which gives the modulo 256
    assign next_sum = sum + wr.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum         <= 8'h00;
            enable_prev <= 1'b0;
            reply       <= '0;
        end else begin
            enable_prev <= enable;
            reply.valid <= 1'b0;
            if (enable && !enable_prev) begin
                // new selection restarts the sum
                sum <= 8'h00;
            end else if (enable && wr.valid) begin
                sum   <= next_sum;
                reply <= '{valid: 1'b1, data: next_sum};
            end
        end
    end

endmodule

// File: rtl/spi_scratch_fifo.sv
// scratch FIFO sub-peripheral: four byte entries, pop for the reply then push the write
`timescale 1ns/1ps

module spi_scratch_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spi_pkg::byte_strobe_t wr,
    output spi_pkg::byte_strobe_t reply
);

    logic [7:0]                     mem [spi_pkg::FIFO_DEPTH];
    logic [spi_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [spi_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [spi_pkg::FIFO_PTR_W:0]   count;
    logic                           empty;
    logic                           full;
    logic                           do_pop;
    logic                           do_push;
    logic                           reply_valid;
    logic [7:0]                     reply_data;

    assign empty = (count == '0);
    assign full  = (count == spi_pkg::FIFO_FULL_COUNT);

    // full is judged before the pop, so a write into a full FIFO is lost
    assign do_pop  = wr.valid & ~empty;
    assign do_push = wr.valid & ~full;

    // ####################
    // pointers and fill level

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            reply_valid <= 1'b0;
        end else begin
            reply_valid <= wr.valid;
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ####################
    // storage and reply data

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.data;
        end
        if (wr.valid) begin
            reply_data <= empty ? spi_pkg::FIFO_EMPTY_REPLY : mem[rd_ptr];
        end
    end

    assign reply = '{valid: reply_valid, data: reply_data};

endmodule

// File: rtl/spi_peripheral_top.sv
// SPI peripheral top: shifter, framer, selector, checksum unit and scratch FIFO
`timescale 1ns/1ps

module spi_peripheral_top (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic copi,
    output logic cipo
);

    spi_pkg::byte_strobe_t rx_byte;
    spi_pkg::byte_strobe_t data_byte;
    spi_pkg::byte_strobe_t tx_byte;
    spi_pkg::byte_strobe_t checksum_wr;
    spi_pkg::byte_strobe_t checksum_reply;
    spi_pkg::byte_strobe_t fifo_wr;
    spi_pkg::byte_strobe_t fifo_reply;

    logic       cs_active;
    logic [7:0] address_in;
    logic       address_valid;
    logic       checksum_enable;

    // ####################
    // pin side

    spi_byte_shifter u_spi_byte_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .copi      (copi),
        .tx_byte   (tx_byte),
        .cipo      (cipo),
        .rx_byte   (rx_byte),
        .cs_active (cs_active)
    );

    spi_transaction_framer u_spi_transaction_framer (
        .clk           (clk),
        .rst_n         (rst_n),
        .cs_active     (cs_active),
        .rx_byte       (rx_byte),
        .address_in    (address_in),
        .address_valid (address_valid),
        .data_byte     (data_byte)
    );

    // ####################
    // sub-peripherals

    // FIFO keeps its contents across selections, so its enable stays open
    spi_subperipheral_selector u_spi_subperipheral_selector (
        .address_in          (address_in),
        .address_valid       (address_valid),
        .peripheral_data_in  (data_byte),
        .peripheral_data_out (tx_byte),
        .checksum_enable     (checksum_enable),
        .checksum_wr         (checksum_wr),
        .checksum_reply      (checksum_reply),
        .fifo_enable         (),
        .fifo_wr             (fifo_wr),
        .fifo_reply          (fifo_reply)
    );

    spi_checksum_unit u_spi_checksum_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (checksum_enable),
        .wr     (checksum_wr),
        .reply  (checksum_reply)
    );

    spi_scratch_fifo u_spi_scratch_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (fifo_wr),
        .reply (fifo_reply)
    );

endmodule

// File: tb/spi_peripheral_props.sv
// concurrent assertions on the selector enables, routed strobes and framer data strobe
`timescale 1ns/1ps

module spi_peripheral_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   address_valid,
    input logic                   checksum_enable,
    input logic                   fifo_enable,
    input spi_pkg::byte_strobe_t  checksum_wr,
    input spi_pkg::byte_strobe_t  fifo_wr,
    input spi_pkg::byte_strobe_t  tx_byte,
    input spi_pkg::framer_state_e framer_state,
    input logic                   data_valid
);

    // count of failed assertions
    int assert_failures = 0;

    // ####################
    // selector

    one_enable: assert property (@(posedge clk) disable iff (!rst_n)
        !(checksum_enable && fifo_enable))
        else begin
            assert_failures++;
            $error("selector drives both sub-peripheral enables");
        end

    // nothing routed without a held address
    quiet_without_address: assert property (@(posedge clk) disable iff (!rst_n)
        !address_valid |-> (checksum_wr == '0 && fifo_wr == '0 && tx_byte == '0
                            && !checksum_enable && !fifo_enable))
        else begin
            assert_failures++;
            $error("selector routes a strobe while address_valid is low");
        end

    // ####################
    // framer

    no_data_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        framer_state == spi_pkg::FR_IDLE |-> !data_valid)
        else begin
            assert_failures++;
            $error("framer pulses data_byte.valid in FR_IDLE");
        end

endmodule

// selector and framer signals as seen from their parent
bind spi_peripheral_top spi_peripheral_props u_spi_peripheral_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .address_valid   (address_valid),
    .checksum_enable (checksum_enable),
    .fifo_enable     (u_spi_subperipheral_selector.fifo_enable),
    .checksum_wr     (checksum_wr),
    .fifo_wr         (fifo_wr),
    .tx_byte         (tx_byte),
    .framer_state    (u_spi_transaction_framer.state),
    .data_valid      (data_byte.valid)
);

// File: tb/tb_spi_peripheral.sv
// testbench for the SPI peripheral: SPI host driver, stimulus table, checksum and FIFO model
`timescale 1ns/1ps

module tb_spi_peripheral;

    logic clk = 1'b0;
    logic rst_n;
    logic sclk;
    logic cs_n;
    logic copi;
    logic cipo;

    // ####################
    // stimulus table, zero data on rows filled from the LCG

    string      row_name   [8] = '{"checksum_sum", "checksum_restart", "fifo_order",
                                   "fifo_drain", "unknown_addr", "fifo_after_unknown",
                                   "fifo_overflow", "checksum_after_unknown"};
    logic [7:0] row_addr   [8] = '{8'hA0, 8'hA0, 8'hB5, 8'hB5, 8'h33, 8'hB5, 8'hB5, 8'hA0};
    int         row_count  [8] = '{4, 3, 4, 3, 4, 2, 4, 4};
    logic [31:0] row_data  [8] = '{32'h010203FE, 32'h10203000, 32'h11223344, 32'h0,
                                   32'h0, 32'h0, 32'h0, 32'h0};
    logic       row_random [8] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};

    logic [31:0] lcg_state = 32'd4908;
    logic [7:0]  model_sum;
    logic [7:0]  model_fifo [$];
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          timeout_cycles;

    spi_peripheral_top u_spi_peripheral_top (
        .clk   (clk),
        .rst_n (rst_n),
        .sclk  (sclk),
        .cs_n  (cs_n),
        .copi  (copi),
        .cipo  (cipo)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected reply to one data byte, updates the model state
    task automatic model_write(input logic [7:0] addr, input logic [7:0] data,
                               output logic [7:0] reply);
        logic was_full;
        reply = 8'h00;
        case (addr)
            spi_pkg::ADDR_CHECKSUM: begin
                model_sum = model_sum + data;
                reply     = model_sum;
            end
            spi_pkg::ADDR_FIFO: begin
                // a full FIFO drops the write even though it pops
                was_full = (model_fifo.size() == spi_pkg::FIFO_DEPTH);
                if (model_fifo.size() == 0) begin
                    reply = spi_pkg::FIFO_EMPTY_REPLY;
                end else begin
                    reply = model_fifo.pop_front();
                end
                if (!was_full) begin
                    model_fifo.push_back(data);
                end
            end
            default: begin
                reply = 8'h00;
            end
        endcase
    endtask

    // mode 0 host, each sclk phase 8 clk, cipo read at the rising edge
    task automatic spi_transfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            copi <= tx[i];
            repeat (8) @(negedge clk);
            sclk  <= 1'b1;
            rx[i] = cipo;
            repeat (8) @(negedge clk);
            sclk <= 1'b0;
        end
    endtask

    task automatic run_row(input int r);
        logic [7:0] data_bytes [4];
        logic [7:0] replies [4];
        logic [7:0] expected;
        logic [7:0] actual;
        logic [7:0] tx;
        int         errors_before;
        errors_before = error_count;
        for (int i = 0; i < 4; i++) begin
            if (row_random[r]) begin
                lcg_state     = lcg_next(lcg_state);
                data_bytes[i] = lcg_state[23:16];
            end else begin
                data_bytes[i] = row_data[r][31 - 8 * i -: 8];
            end
        end
        // each checksum selection starts from zero
        if (row_addr[r] == spi_pkg::ADDR_CHECKSUM) begin
            model_sum = 8'h00;
        end
        for (int i = 0; i < row_count[r]; i++) begin
            model_write(row_addr[r], data_bytes[i], replies[i]);
        end
        cs_n <= 1'b0;
        repeat (3) @(negedge clk);
        for (int p = 0; p <= row_count[r]; p++) begin
            if (p == 0) begin
                tx = row_addr[r];
            end else begin
                tx = data_bytes[p - 1];
            end
            if (p < 2) begin
                expected = 8'h00;
            end else begin
                expected = replies[p - 2];
            end
            spi_transfer_byte(tx, actual);
            check_count++;
            if (actual !== expected) begin
                error_count++;
                $display("[FAIL] %s byte %0d: expected 0x%02h, actual 0x%02h",
                         row_name[r], p, expected, actual);
            end
        end
        repeat (3) @(negedge clk);
        cs_n <= 1'b1;
        repeat (6) @(negedge clk);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok, %0d bytes", row_name[r], row_count[r] + 1);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", row_name[r], error_count - errors_before);
        end
    endtask

    // ####################
    // main sequence

    initial begin
        timeout_cycles = $size(row_addr) * 5 * 8 * 16 + 200;
        rst_n     = 1'b0;
        sclk      = 1'b0;
        cs_n      = 1'b1;
        copi      = 1'b0;
        model_sum = 8'h00;
        repeat (5) @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        tests_run++;
        check_count++;
        if (cipo !== 1'b0) begin
            error_count++;
            tests_failed++;
            $display("[FAIL] reset_state: expected 0, actual %b", cipo);
        end else begin
            $display("test reset_state: ok");
        end
        for (int r = 0; r < $size(row_addr); r++) begin
            run_row(r);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d assertion errors",
                 tests_run, tests_run - tests_failed, tests_failed, check_count,
                 u_spi_peripheral_top.u_spi_peripheral_props.assert_failures);
        if (error_count == 0
                && u_spi_peripheral_top.u_spi_peripheral_props.assert_failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
rtl/spi_pkg.sv
rtl/spi_byte_shifter.sv
rtl/spi_transaction_framer.sv
rtl/spi_subperipheral_selector.sv
rtl/spi_checksum_unit.sv
rtl/spi_scratch_fifo.sv
rtl/spi_peripheral_top.sv
tb/spi_peripheral_props.sv
tb/tb_spi_peripheral.sv
